// File: source/mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int MEM_ADDR_WIDTH   = 16;
    localparam int MEM_DATA_WIDTH   = 32;
    localparam int MEM_BYTEEN_WIDTH = MEM_DATA_WIDTH / 8;
    localparam int CORE_TAG_WIDTH   = 4;

    // Tag field at the memory port has room for up to 16 clusters
    localparam int CLUSTER_IDX_MAX_BITS = 4;
    localparam int MEM_TAG_MAX_WIDTH    = CORE_TAG_WIDTH + CLUSTER_IDX_MAX_BITS;

    typedef struct packed {
        logic                        valid;
        logic                        rw;
        logic [MEM_ADDR_WIDTH-1:0]   addr;
        logic [MEM_BYTEEN_WIDTH-1:0] byteen;
        logic [MEM_DATA_WIDTH-1:0]   data;
        logic [CORE_TAG_WIDTH-1:0]   tag;
    } core_req_t;

    typedef struct packed {
        logic                        valid;
        logic [MEM_DATA_WIDTH-1:0]   data;
        logic [CORE_TAG_WIDTH-1:0]   tag;
    } core_rsp_t;

    // Tag layout is {cluster index, core tag}, zero extended to the full field
    typedef struct packed {
        logic                         valid;
        logic                         rw;
        logic [MEM_ADDR_WIDTH-1:0]    addr;
        logic [MEM_BYTEEN_WIDTH-1:0]  byteen;
        logic [MEM_DATA_WIDTH-1:0]    data;
        logic [MEM_TAG_MAX_WIDTH-1:0] tag;
    } mem_req_t;

    typedef struct packed {
        logic                         valid;
        logic [MEM_DATA_WIDTH-1:0]    data;
        logic [MEM_TAG_MAX_WIDTH-1:0] tag;
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: source/dcr_pkg.sv
`default_nettype none

package dcr_pkg;

    localparam int DCR_ADDR_WIDTH = 4;
    localparam int DCR_DATA_WIDTH = 32;

    typedef enum logic [DCR_ADDR_WIDTH-1:0] {
        DCR_BASE_ADDR   = 4'h0,
        DCR_COUNT       = 4'h1,
        DCR_FILL_VALUE  = 4'h2,
        DCR_RESULT_ADDR = 4'h3,
        DCR_START       = 4'h4
    } dcr_addr_e;

    // Carried in bit 0 of the DCR_START data
    typedef enum logic {
        OP_FILL = 1'b0,
        OP_SUM  = 1'b1
    } kernel_op_e;

    typedef struct packed {
        logic                      valid;
        logic [DCR_ADDR_WIDTH-1:0] addr;
        logic [DCR_DATA_WIDTH-1:0] data;
    } dcr_write_t;

endpackage

`default_nettype wire

// File: source/cluster_core.sv
`timescale 1ns/1ns
`default_nettype none

module cluster_core #(
    parameter int CLUSTER_ID      = 0,
    parameter int MAX_OUTSTANDING = 8
) (
    input  wire                      clk,
    input  wire                      reset,
    input  wire dcr_pkg::dcr_write_t dcr_wr,
    output mem_pkg::core_req_t       core_req,
    input  wire                      core_req_ready,
    input  wire mem_pkg::core_rsp_t  core_rsp,
    output logic                     busy
);

    import mem_pkg::*;
    import dcr_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        DRAIN,
        WRITEBACK
    } state_e;

    localparam int OUT_WIDTH = $clog2(MAX_OUTSTANDING + 1);

    state_e                    state;
    kernel_op_e                op;
    logic [MEM_ADDR_WIDTH-1:0] count;
    logic [MEM_ADDR_WIDTH-1:0] base_addr;
    logic [MEM_ADDR_WIDTH-1:0] result_addr;
    logic [MEM_ADDR_WIDTH-1:0] slice_addr;
    logic [MEM_DATA_WIDTH-1:0] fill_value;
    logic [MEM_DATA_WIDTH-1:0] sum_acc;

    logic [MEM_ADDR_WIDTH-1:0] issue_cnt;
    logic [MEM_ADDR_WIDTH-1:0] rsp_cnt;
    logic [OUT_WIDTH-1:0]      outstanding;
    logic [CORE_TAG_WIDTH-1:0] req_tag;

    logic req_fire;
    logic rd_fire;
    logic cfg_wr;
    logic issue_done;
    logic last_issue;

    assign req_fire   = core_req.valid && core_req_ready;
    assign rd_fire    = req_fire && !core_req.rw;
    assign cfg_wr     = (state == IDLE) && dcr_wr.valid;
    assign issue_done = (issue_cnt == count);
    assign last_issue = (state == ISSUE) && req_fire && (issue_cnt + 1'b1 == count);

    // Configuration is frozen while a kernel runs
    always_ff @(posedge clk) begin
        if (cfg_wr) begin
            case (dcr_wr.addr)
                DCR_BASE_ADDR:   base_addr   <= dcr_wr.data[MEM_ADDR_WIDTH-1:0];
                DCR_FILL_VALUE:  fill_value  <= dcr_wr.data;
                DCR_RESULT_ADDR: result_addr <= dcr_wr.data[MEM_ADDR_WIDTH-1:0];
                DCR_START:       slice_addr  <= base_addr + MEM_ADDR_WIDTH'(CLUSTER_ID) * count;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= IDLE;
            op          <= OP_FILL;
            count       <= '0;
            issue_cnt   <= '0;
            rsp_cnt     <= '0;
            outstanding <= '0;
            req_tag     <= '0;
        end else begin
            if (req_fire) begin
                req_tag <= req_tag + 1'b1;
            end
            outstanding <= outstanding + OUT_WIDTH'(rd_fire) - OUT_WIDTH'(core_rsp.valid);
            if (core_rsp.valid) begin
                rsp_cnt <= rsp_cnt + 1'b1;
            end

            case (state)
                IDLE: begin
                    if (cfg_wr && dcr_wr.addr == DCR_COUNT) begin
                        count <= dcr_wr.data[MEM_ADDR_WIDTH-1:0];
                    end
                    if (cfg_wr && dcr_wr.addr == DCR_START) begin
                        op        <= kernel_op_e'(dcr_wr.data[0]);
                        issue_cnt <= '0;
                        rsp_cnt   <= '0;
                        state     <= ISSUE;
                    end
                end
                ISSUE: begin
                    if (req_fire) begin
                        issue_cnt <= issue_cnt + 1'b1;
                    end
                    // Leave on the last transfer, or at once for a zero count
                    if (issue_done || last_issue) begin
                        state <= (op == OP_FILL) ? IDLE : DRAIN;
                    end
                end
                DRAIN: begin
                    if (rsp_cnt == count) begin
                        state <= WRITEBACK;
                    end
                end
                WRITEBACK: begin
                    if (req_fire) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Sum restarts from zero at every kernel launch
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            sum_acc <= '0;
        end else if (core_rsp.valid) begin
            sum_acc <= sum_acc + core_rsp.data;
        end
    end

    always_comb begin
        core_req        = '0;
        core_req.byteen = '1;
        core_req.tag    = req_tag;
        case (state)
            ISSUE: begin
                core_req.valid = !issue_done &&
                                 (op == OP_FILL || outstanding < OUT_WIDTH'(MAX_OUTSTANDING));
                core_req.rw    = (op == OP_FILL);
                core_req.addr  = slice_addr + issue_cnt;
                core_req.data  = fill_value;
            end
            WRITEBACK: begin
                core_req.valid = 1'b1;
                core_req.rw    = 1'b1;
                core_req.addr  = result_addr + MEM_ADDR_WIDTH'(CLUSTER_ID);
                core_req.data  = sum_acc;
            end
            default: ;
        endcase
    end

    assign busy = (state != IDLE);

endmodule

`default_nettype wire

// File: source/mem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter #(
    parameter int NUM_CLUSTERS  = 4,
    parameter int QUEUE_DEPTH   = 4,
    parameter int MEM_TAG_WIDTH = 6
) (
    input  wire                                         clk,
    input  wire                                         reset,
    input  wire mem_pkg::core_req_t [NUM_CLUSTERS-1:0] core_req,
    output logic [NUM_CLUSTERS-1:0]                     core_req_ready,
    output mem_pkg::core_rsp_t [NUM_CLUSTERS-1:0]       core_rsp,
    output mem_pkg::mem_req_t                           mem_req,
    input  wire                                         mem_req_ready,
    input  wire mem_pkg::mem_rsp_t                      mem_rsp
);

    import mem_pkg::*;

    localparam int CLUSTER_BITS = MEM_TAG_WIDTH - CORE_TAG_WIDTH;
    localparam int PTR_WIDTH    = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_WIDTH    = $clog2(QUEUE_DEPTH + 1);

    mem_req_t queue [QUEUE_DEPTH];

    logic [PTR_WIDTH-1:0]    wr_ptr;
    logic [PTR_WIDTH-1:0]    rd_ptr;
    logic [CNT_WIDTH-1:0]    fill_cnt;
    logic [CLUSTER_BITS-1:0] rr_ptr;

    logic                    grant_valid;
    logic [CLUSTER_BITS-1:0] grant_idx;
    logic                    full;
    logic                    push;
    logic                    pop;
    mem_req_t                push_entry;

    // Search starts at the cluster after the last one granted
    always_comb begin
        int idx;
        grant_valid = 1'b0;
        grant_idx   = '0;
        for (int k = 0; k < NUM_CLUSTERS; k++) begin
            idx = (int'(rr_ptr) + k) % NUM_CLUSTERS;
            if (!grant_valid && core_req[idx].valid) begin
                grant_valid = 1'b1;
                grant_idx   = CLUSTER_BITS'(idx);
            end
        end
    end

    assign full = (fill_cnt == CNT_WIDTH'(QUEUE_DEPTH));
    assign push = grant_valid && !full;
    assign pop  = mem_req.valid && mem_req_ready;

    always_comb begin
        for (int i = 0; i < NUM_CLUSTERS; i++) begin
            core_req_ready[i] = push && (grant_idx == CLUSTER_BITS'(i));
        end
    end

    always_comb begin
        push_entry        = '0;
        push_entry.valid  = 1'b1;
        push_entry.rw     = core_req[grant_idx].rw;
        push_entry.addr   = core_req[grant_idx].addr;
        push_entry.byteen = core_req[grant_idx].byteen;
        push_entry.data   = core_req[grant_idx].data;
        push_entry.tag    = MEM_TAG_MAX_WIDTH'({grant_idx, core_req[grant_idx].tag});
    end

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill_cnt <= '0;
            rr_ptr   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                rr_ptr <= (grant_idx == CLUSTER_BITS'(NUM_CLUSTERS - 1)) ? '0
                                                                         : grant_idx + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            fill_cnt <= fill_cnt + CNT_WIDTH'(push) - CNT_WIDTH'(pop);
        end
    end

    // Head entry stays put until memory takes it
    always_comb begin
        mem_req       = queue[rd_ptr];
        mem_req.valid = (fill_cnt != '0);
    end

    // Upper tag bits select the cluster
    always_comb begin
        for (int i = 0; i < NUM_CLUSTERS; i++) begin
            core_rsp[i].valid = mem_rsp.valid &&
                                (mem_rsp.tag[MEM_TAG_WIDTH-1:CORE_TAG_WIDTH] ==
                                 CLUSTER_BITS'(i));
            core_rsp[i].data  = mem_rsp.data;
            core_rsp[i].tag   = mem_rsp.tag[CORE_TAG_WIDTH-1:0];
        end
    end

endmodule

`default_nettype wire

// File: source/mem_perf.sv
`timescale 1ns/1ns
`default_nettype none

module mem_perf #(
    parameter int PERF_CTR_WIDTH = 32
) (
    input  wire                       clk,
    input  wire                       reset,
    input  wire mem_pkg::mem_req_t    mem_req,
    input  wire                       mem_req_ready,
    input  wire mem_pkg::mem_rsp_t    mem_rsp,
    output logic [PERF_CTR_WIDTH-1:0] perf_mem_reads,
    output logic [PERF_CTR_WIDTH-1:0] perf_mem_writes,
    output logic [PERF_CTR_WIDTH-1:0] perf_mem_latency
);

    logic req_fire;
    logic rd_fire;
    logic wr_fire;
    logic rsp_fire;

    logic [PERF_CTR_WIDTH-1:0] pending_reads;

    assign req_fire = mem_req.valid && mem_req_ready;
    assign rd_fire  = req_fire && !mem_req.rw;
    assign wr_fire  = req_fire && mem_req.rw;
    // Responses are never stalled
    assign rsp_fire = mem_rsp.valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending_reads    <= '0;
            perf_mem_reads   <= '0;
            perf_mem_writes  <= '0;
            perf_mem_latency <= '0;
        end else begin
            pending_reads <= pending_reads + PERF_CTR_WIDTH'(rd_fire)
                                           - PERF_CTR_WIDTH'(rsp_fire);
            if (rd_fire) begin
                perf_mem_reads <= perf_mem_reads + 1'b1;
            end
            if (wr_fire) begin
                perf_mem_writes <= perf_mem_writes + 1'b1;
            end
            // Every read in flight adds one cycle per clock
            perf_mem_latency <= perf_mem_latency + pending_reads;
        end
    end

endmodule

`default_nettype wire

// File: source/gpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module gpu_top #(
    parameter int NUM_CLUSTERS    = 4,
    parameter int QUEUE_DEPTH     = 4,
    parameter int MAX_OUTSTANDING = 8,
    parameter int PERF_CTR_WIDTH  = 32
) (
    input  wire                       clk,
    input  wire                       reset,
    output mem_pkg::mem_req_t         mem_req,
    input  wire                       mem_req_ready,
    input  wire mem_pkg::mem_rsp_t    mem_rsp,
    input  wire dcr_pkg::dcr_write_t  dcr_wr,
    output logic                      busy,
    output logic [PERF_CTR_WIDTH-1:0] perf_mem_reads,
    output logic [PERF_CTR_WIDTH-1:0] perf_mem_writes,
    output logic [PERF_CTR_WIDTH-1:0] perf_mem_latency
);

    import mem_pkg::*;
    import dcr_pkg::*;

    // Cluster index sits above the core tag, limited to MEM_TAG_MAX_WIDTH
    localparam int CLUSTER_BITS  = (NUM_CLUSTERS > 1) ? $clog2(NUM_CLUSTERS) : 1;
    localparam int MEM_TAG_WIDTH = CORE_TAG_WIDTH + CLUSTER_BITS;

    dcr_write_t dcr_bcast;

    core_req_t [NUM_CLUSTERS-1:0] cluster_req;
    core_rsp_t [NUM_CLUSTERS-1:0] cluster_rsp;
    logic      [NUM_CLUSTERS-1:0] cluster_req_ready;
    logic      [NUM_CLUSTERS-1:0] cluster_busy;

    // One register stage in front of the DCR fan-out
    always_ff @(posedge clk) begin
        if (reset) begin
            dcr_bcast.valid <= 1'b0;
        end else begin
            dcr_bcast.valid <= dcr_wr.valid;
        end
        dcr_bcast.addr <= dcr_wr.addr;
        dcr_bcast.data <= dcr_wr.data;
    end

    for (genvar i = 0; i < NUM_CLUSTERS; i++) begin : g_cluster
        cluster_core #(
            .CLUSTER_ID      (i),
            .MAX_OUTSTANDING (MAX_OUTSTANDING)
        ) cluster_i (
            .clk            (clk),
            .reset          (reset),
            .dcr_wr         (dcr_bcast),
            .core_req       (cluster_req[i]),
            .core_req_ready (cluster_req_ready[i]),
            .core_rsp       (cluster_rsp[i]),
            .busy           (cluster_busy[i])
        );
    end

    mem_arbiter #(
        .NUM_CLUSTERS  (NUM_CLUSTERS),
        .QUEUE_DEPTH   (QUEUE_DEPTH),
        .MEM_TAG_WIDTH (MEM_TAG_WIDTH)
    ) arbiter_i (
        .clk            (clk),
        .reset          (reset),
        .core_req       (cluster_req),
        .core_req_ready (cluster_req_ready),
        .core_rsp       (cluster_rsp),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp        (mem_rsp)
    );

    mem_perf #(
        .PERF_CTR_WIDTH (PERF_CTR_WIDTH)
    ) perf_i (
        .clk              (clk),
        .reset            (reset),
        .mem_req          (mem_req),
        .mem_req_ready    (mem_req_ready),
        .mem_rsp          (mem_rsp),
        .perf_mem_reads   (perf_mem_reads),
        .perf_mem_writes  (perf_mem_writes),
        .perf_mem_latency (perf_mem_latency)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else begin
            busy <= |cluster_busy;
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_mem_model.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mem_model #(
    parameter logic [31:0] SEED = 32'd35
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    backpressure,
    input  wire mem_pkg::mem_req_t mem_req,
    output logic                   mem_req_ready,
    output mem_pkg::mem_rsp_t      mem_rsp
);

    import mem_pkg::*;

    typedef struct packed {
        logic [31:0]                  due;
        logic [MEM_DATA_WIDTH-1:0]    data;
        logic [MEM_TAG_MAX_WIDTH-1:0] tag;
    } read_entry_t;

    logic [MEM_DATA_WIDTH-1:0] mem [2**MEM_ADDR_WIDTH];
    read_entry_t               read_q [$];
    logic [31:0]               lcg_state;
    logic [31:0]               cycle;
    logic [31:0]               last_due;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    initial begin
        lcg_state = SEED;
        mem_req_ready <= 1'b1;
        mem_rsp       <= '0;
        // Address mixed in so the pattern covers every address bit
        for (int a = 0; a < 2**MEM_ADDR_WIDTH; a++) begin
            mem[a] = lcg_next() ^ 32'(a);
        end
    end

    always @(posedge clk) begin
        read_entry_t entry;
        mem_rsp_t    rsp;
        logic [31:0] rnd;
        rsp = '0;
        if (reset) begin
            read_q.delete();
            cycle    = '0;
            last_due = '0;
            mem_req_ready <= 1'b1;
        end else begin
            cycle = cycle + 1;
            // In order, at most one response per cycle
            if (read_q.size() > 0 && read_q[0].due <= cycle) begin
                entry     = read_q.pop_front();
                rsp.valid = 1'b1;
                rsp.data  = entry.data;
                rsp.tag   = entry.tag;
            end
            if (mem_req.valid && mem_req_ready) begin
                if (mem_req.rw) begin
                    for (int b = 0; b < MEM_BYTEEN_WIDTH; b++) begin
                        if (mem_req.byteen[b]) begin
                            mem[mem_req.addr][8*b +: 8] = mem_req.data[8*b +: 8];
                        end
                    end
                end else begin
                    rnd       = lcg_next();
                    entry.due = cycle + 1 + (rnd >> 29);
                    if (entry.due <= last_due) begin
                        entry.due = last_due + 1;
                    end
                    entry.data = mem[mem_req.addr];
                    entry.tag  = mem_req.tag;
                    last_due   = entry.due;
                    read_q.push_back(entry);
                end
            end
            rnd = lcg_next();
            mem_req_ready <= !backpressure || (rnd[31:30] != 2'b00);
        end
        mem_rsp <= rsp;
    end

endmodule

`default_nettype wire

// File: tb/tb_gpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_gpu_top;

    import mem_pkg::*;
    import dcr_pkg::*;

    localparam int NUM_CLUSTERS    = 4;
    localparam int QUEUE_DEPTH     = 4;
    localparam int MAX_OUTSTANDING = 8;
    localparam int PERF_CTR_WIDTH  = 32;
    localparam int NUM_TESTS       = 6;
    localparam int MAX_COUNT       = 20;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * (NUM_CLUSTERS * MAX_COUNT * 16 + 200);

    localparam logic [15:0] SUM_BASE    = 16'h0100;
    localparam logic [15:0] FILL_BASE   = 16'h0200;
    localparam logic [15:0] RESULT_BASE = 16'h0400;
    localparam logic [31:0] FILL_VALUE  = 32'hA5C3_0F1E;

    logic                      clk;
    logic                      reset;
    logic                      backpressure;
    dcr_write_t                dcr_wr;
    mem_req_t                  mem_req;
    logic                      mem_req_ready;
    mem_rsp_t                  mem_rsp;
    logic                      busy;
    logic [PERF_CTR_WIDTH-1:0] perf_mem_reads;
    logic [PERF_CTR_WIDTH-1:0] perf_mem_writes;
    logic [PERF_CTR_WIDTH-1:0] perf_mem_latency;

    logic [MEM_DATA_WIDTH-1:0] ref_mem [2**MEM_ADDR_WIDTH];
    int errors = 0;
    int tests_failed = 0;
    int errors_at_test_start = 0;
    int cluster_reads [NUM_CLUSTERS];

    gpu_top #(
        .NUM_CLUSTERS    (NUM_CLUSTERS),
        .QUEUE_DEPTH     (QUEUE_DEPTH),
        .MAX_OUTSTANDING (MAX_OUTSTANDING),
        .PERF_CTR_WIDTH  (PERF_CTR_WIDTH)
    ) dut_i (
        .clk              (clk),
        .reset            (reset),
        .mem_req          (mem_req),
        .mem_req_ready    (mem_req_ready),
        .mem_rsp          (mem_rsp),
        .dcr_wr           (dcr_wr),
        .busy             (busy),
        .perf_mem_reads   (perf_mem_reads),
        .perf_mem_writes  (perf_mem_writes),
        .perf_mem_latency (perf_mem_latency)
    );

    tb_mem_model mem_model_i (
        .clk           (clk),
        .reset         (reset),
        .backpressure  (backpressure),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp       (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    // Reads each cluster handed to the arbiter and not yet answered
    always @(posedge clk) begin
        for (int k = 0; k < NUM_CLUSTERS; k++) begin
            if (reset) begin
                cluster_reads[k] <= 0;
            end else begin
                cluster_reads[k] <= cluster_reads[k]
                                    + int'(dut_i.cluster_req[k].valid &&
                                           dut_i.cluster_req_ready[k] &&
                                           !dut_i.cluster_req[k].rw)
                                    - int'(dut_i.cluster_rsp[k].valid);
            end
        end
    end

    req_stable: assert property (@(posedge clk) disable iff (reset)
        mem_req.valid && !mem_req_ready |=> $stable(mem_req))
    else begin
        $display("mem_req changed while it was valid and not accepted");
        errors++;
    end

    for (genvar k = 0; k < NUM_CLUSTERS; k++) begin : g_rsp_check
        rsp_has_read: assert property (@(posedge clk) disable iff (reset)
            dut_i.cluster_rsp[k].valid |-> cluster_reads[k] > 0)
        else begin
            $display("Cluster %0d got a response with no read pending", k);
            errors++;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("** Error: %s expected 0x%08h got 0x%08h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic finish_test(input int num, input string name);
        if (errors == errors_at_test_start) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - errors_at_test_start);
            tests_failed++;
        end
        errors_at_test_start = errors;
    endtask

    task automatic dcr_write(input dcr_addr_e addr, input logic [31:0] data);
        @(posedge clk);
        dcr_wr.valid <= 1'b1;
        dcr_wr.addr  <= addr;
        dcr_wr.data  <= data;
        @(posedge clk);
        dcr_wr.valid <= 1'b0;
    endtask

    task automatic configure(input logic [15:0] base, input int count,
                             input logic [31:0] fill, input logic [15:0] result);
        dcr_write(DCR_BASE_ADDR, 32'(base));
        dcr_write(DCR_COUNT, 32'(count));
        dcr_write(DCR_FILL_VALUE, fill);
        dcr_write(DCR_RESULT_ADDR, 32'(result));
    endtask

    task automatic wait_busy_rise();
        @(negedge clk);
        while (!busy) @(negedge clk);
    endtask

    // Done once busy is low and the request queue has drained to memory
    task automatic wait_idle();
        @(negedge clk);
        while (busy || mem_req.valid) @(negedge clk);
    endtask

    task automatic run_kernel(input kernel_op_e op);
        dcr_write(DCR_START, 32'(op));
        wait_busy_rise();
        wait_idle();
    endtask

    function automatic logic [31:0] slice_sum(input logic [15:0] start, input int count);
        logic [31:0] total;
        total = '0;
        for (int i = 0; i < count; i++) begin
            total += ref_mem[16'(start + i)];
        end
        return total;
    endfunction

    task automatic check_sums(input logic [15:0] base, input int count,
                              input logic [15:0] result);
        logic [15:0] addr;
        for (int k = 0; k < NUM_CLUSTERS; k++) begin
            addr = result + 16'(k);
            check_value($sformatf("mem[0x%04h]", addr), slice_sum(base + 16'(k * count), count),
                        mem_model_i.mem[addr]);
        end
    endtask

    task automatic check_fill(input logic [15:0] base, input int count, input logic [31:0] value);
        logic [15:0] addr;
        for (int i = 0; i < NUM_CLUSTERS * count; i++) begin
            addr = base + 16'(i);
            check_value($sformatf("mem[0x%04h]", addr), value, mem_model_i.mem[addr]);
        end
        // Neighbors of the filled range keep their preload
        addr = base - 16'd1;
        check_value($sformatf("mem[0x%04h]", addr), ref_mem[addr], mem_model_i.mem[addr]);
        addr = base + 16'(NUM_CLUSTERS * count);
        check_value($sformatf("mem[0x%04h]", addr), ref_mem[addr], mem_model_i.mem[addr]);
    endtask

    initial begin
        reset        <= 1'b1;
        backpressure <= 1'b0;
        dcr_wr       <= '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        for (int a = 0; a < 2**MEM_ADDR_WIDTH; a++) begin
            ref_mem[a] = mem_model_i.mem[a];
        end

        check_value("busy", 32'd0, 32'(busy));
        check_value("mem_req.valid", 32'd0, 32'(mem_req.valid));
        check_value("perf_mem_reads", 32'd0, perf_mem_reads);
        check_value("perf_mem_writes", 32'd0, perf_mem_writes);
        check_value("perf_mem_latency", 32'd0, perf_mem_latency);
        finish_test(1, "reset state");

        configure(FILL_BASE, 16, FILL_VALUE, RESULT_BASE);
        run_kernel(OP_FILL);
        check_fill(FILL_BASE, 16, FILL_VALUE);
        finish_test(2, "fill");

        configure(SUM_BASE, 20, '0, RESULT_BASE);
        run_kernel(OP_SUM);
        check_sums(SUM_BASE, 20, RESULT_BASE);
        finish_test(3, "sum");

        @(posedge clk);
        backpressure <= 1'b1;
        configure(SUM_BASE, 20, '0, RESULT_BASE + 16'h0010);
        run_kernel(OP_SUM);
        check_sums(SUM_BASE, 20, RESULT_BASE + 16'h0010);
        @(posedge clk);
        backpressure <= 1'b0;
        finish_test(4, "sum with back-pressure");

        check_value("perf_mem_reads", 32'(2 * NUM_CLUSTERS * 20), perf_mem_reads);
        check_value("perf_mem_writes", 32'(NUM_CLUSTERS * 16 + 2 * NUM_CLUSTERS),
                    perf_mem_writes);
        assert (perf_mem_latency >= perf_mem_reads) else begin
            $display("** Error: perf_mem_latency 0x%08h below perf_mem_reads 0x%08h",
                     perf_mem_latency, perf_mem_reads);
            errors++;
        end
        finish_test(5, "perf counters");

        // COUNT written mid-run must be dropped
        configure(SUM_BASE, 20, '0, RESULT_BASE + 16'h0020);
        dcr_write(DCR_START, 32'(OP_SUM));
        wait_busy_rise();
        dcr_write(DCR_COUNT, 32'd8);
        @(negedge clk);
        check_value("busy", 32'd1, 32'(busy));
        wait_idle();
        check_sums(SUM_BASE, 20, RESULT_BASE + 16'h0020);
        dcr_write(DCR_RESULT_ADDR, 32'(RESULT_BASE + 16'h0030));
        run_kernel(OP_SUM);
        check_sums(SUM_BASE, 20, RESULT_BASE + 16'h0030);
        dcr_write(DCR_COUNT, 32'd8);
        dcr_write(DCR_RESULT_ADDR, 32'(RESULT_BASE + 16'h0040));
        run_kernel(OP_SUM);
        check_sums(SUM_BASE, 8, RESULT_BASE + 16'h0040);
        finish_test(6, "DCR write while busy");

        $display("%0d tests run, %0d failed, %0d errors", NUM_TESTS, tests_failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: gpu_top.f
source/mem_pkg.sv
source/dcr_pkg.sv
source/cluster_core.sv
source/mem_arbiter.sv
source/mem_perf.sv
source/gpu_top.sv
tb/tb_mem_model.sv
tb/tb_gpu_top.sv
